/* source/frontend_params.svh */
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// address and instruction word width
`define FE_XLEN 32

// entries held between scan and decode
`define FE_QUEUE_DEPTH 8

// rv32i major opcodes seen by the scan stage
`define FE_OPC_BRANCH 7'b1100011
`define FE_OPC_JAL    7'b1101111
`define FE_OPC_JALR   7'b1100111

`endif

/* source/frontend_pkg.sv */
`include "frontend_params.svh"

package frontend_pkg;

  // kind of control flow found in a fetched word
  typedef enum logic [1:0] {
    CF_NONE,
    CF_BRANCH,
    CF_JUMP,
    CF_JUMPR
  } cf_e;

  // ------------------------------------------------------------
  // instruction memory handshake
  // ------------------------------------------------------------
  typedef struct packed {
    logic               valid;
    logic [`FE_XLEN-1:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic               valid;
    logic [`FE_XLEN-1:0] data;
  } imem_rsp_t;

  // backend misprediction and scan stage prediction
  typedef struct packed {
    logic               valid;
    logic [`FE_XLEN-1:0] target;
  } resolve_t;

  typedef struct packed {
    logic               taken;
    logic [`FE_XLEN-1:0] target;
  } predict_t;

  // one entry handed to decode
  typedef struct packed {
    logic [`FE_XLEN-1:0] pc;
    logic [`FE_XLEN-1:0] instr;
    cf_e                cf;
    logic               taken;
    logic [`FE_XLEN-1:0] target;
  } fetch_entry_t;

  // ------------------------------------------------------------
  // instruction word views
  // ------------------------------------------------------------
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } btype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jtype_t;

  // same word read as branch or as jump
  typedef union packed {
    btype_t b;
    jtype_t j;
  } instr_u;

endpackage

/* source/pc_gen.sv */
`timescale 1ns/1ns
`include "frontend_params.svh"

module pc_gen
  import frontend_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`FE_XLEN-1:0] boot_addr_i,
  input  logic                ex_valid_i,
  input  logic [`FE_XLEN-1:0] trap_vector_i,
  input  logic                eret_i,
  input  logic [`FE_XLEN-1:0] epc_i,
  input  resolve_t            resolve_i,
  input  predict_t            predict_i,
  input  logic                room_i,
  input  logic                imem_ready_i,
  output imem_req_t           imem_req_o,
  output logic                flush_o,
  output logic                drop_o
);

  logic [`FE_XLEN-1:0] npc_d, npc_q;
  // high in the first cycle out of reset
  logic                load_boot_q;
  logic                accepted;
  logic                drop_q;

  // ------------------------------------------------------------
  // memory request
  // ------------------------------------------------------------
  // no request until the boot address is loaded
  assign imem_req_o.valid = ~load_boot_q & room_i;
  // force word alignment
  assign imem_req_o.addr  = {npc_q[`FE_XLEN-1:2], 2'b00};
  assign accepted         = imem_req_o.valid & imem_ready_i;

  // any backend redirect kills the path behind it
  assign flush_o = ex_valid_i | eret_i | resolve_i.valid;

  // ------------------------------------------------------------
  // next pc select
  // ------------------------------------------------------------
  // later assignments win, lowest priority first
  always_comb begin
    if (load_boot_q) begin
      npc_d = boot_addr_i;
    end else begin
      npc_d = npc_q;
    end
    // sequential step after an accepted request
    if (accepted) begin
      npc_d = imem_req_o.addr + `FE_XLEN'd4;
    end
    // static prediction from the scan stage
    if (predict_i.taken) begin
      npc_d = predict_i.target;
    end
    // resolved misprediction
    if (resolve_i.valid) begin
      npc_d = resolve_i.target;
    end
    // return from exception
    if (eret_i) begin
      npc_d = epc_i;
    end
    // exception entry on top
    if (ex_valid_i) begin
      npc_d = trap_vector_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_boot_q <= 1'b1;
      npc_q       <= '0;
      drop_q      <= 1'b0;
    end else begin
      load_boot_q <= 1'b0;
      npc_q       <= npc_d;
      // request on the old path, its response is thrown away
      drop_q      <= accepted & (flush_o | predict_i.taken);
    end
  end

  // lines up with the response one cycle later
  assign drop_o = drop_q;

endmodule

/* source/scan_stage.sv */
`timescale 1ns/1ns
`include "frontend_params.svh"

module scan_stage
  import frontend_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  imem_rsp_t           imem_rsp_i,
  input  logic [`FE_XLEN-1:0] req_addr_i,
  input  logic                drop_i,
  input  logic                flush_i,
  output predict_t            predict_o,
  output logic                push_o,
  output fetch_entry_t        entry_o
);

  // bus address of the previous cycle
  logic [`FE_XLEN-1:0] addr_q;
  // registered response
  logic                valid_q;
  logic [`FE_XLEN-1:0] pc_q;
  logic [`FE_XLEN-1:0] instr_q;

  instr_u              word;
  logic                is_branch;
  logic                is_jal;
  logic                is_jalr;
  logic [`FE_XLEN-1:0] b_imm;
  logic [`FE_XLEN-1:0] j_imm;
  logic                taken;
  logic [`FE_XLEN-1:0] target;
  cf_e                 cf;

  // ------------------------------------------------------------
  // response register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else begin
      // sequential word behind a taken prediction is off path
      valid_q <= imem_rsp_i.valid & ~drop_i & ~predict_o.taken;
    end
  end

  // payload follows the bus, qualified by valid_q
  always_ff @(posedge clk_i) begin
    addr_q <= req_addr_i;
    if (imem_rsp_i.valid) begin
      // response belongs to the request accepted last cycle
      pc_q    <= addr_q;
      instr_q <= imem_rsp_i.data;
    end
  end

  // ------------------------------------------------------------
  // control flow decode
  // ------------------------------------------------------------
  assign word = instr_q;

  assign is_branch = (word.b.opcode == `FE_OPC_BRANCH);
  assign is_jal    = (word.j.opcode == `FE_OPC_JAL);
  assign is_jalr   = (word.j.opcode == `FE_OPC_JALR);

  // b-type offset, sign from bit 31
  assign b_imm = {{19{word.b.imm12}}, word.b.imm12, word.b.imm11,
                  word.b.imm10_5, word.b.imm4_1, 1'b0};
  // j-type offset
  assign j_imm = {{11{word.j.imm20}}, word.j.imm20, word.j.imm19_12,
                  word.j.imm11, word.j.imm10_1, 1'b0};

  always_comb begin
    if (is_branch) begin
      cf = CF_BRANCH;
    end else if (is_jal) begin
      cf = CF_JUMP;
    end else if (is_jalr) begin
      cf = CF_JUMPR;
    end else begin
      cf = CF_NONE;
    end
  end

  // static rule
  // jal always taken, backward branch taken, jalr never predicted
  assign taken = valid_q & (is_jal | (is_branch & b_imm[`FE_XLEN-1]));

  // predicted next pc of this instruction
  assign target = taken ? pc_q + (is_jal ? j_imm : b_imm) : pc_q + `FE_XLEN'd4;

  assign predict_o.taken  = taken;
  assign predict_o.target = target;

  // ------------------------------------------------------------
  // push towards the queue
  // ------------------------------------------------------------
  assign push_o         = valid_q;
  assign entry_o.pc     = pc_q;
  assign entry_o.instr  = instr_q;
  assign entry_o.cf     = cf;
  assign entry_o.taken  = taken;
  assign entry_o.target = target;

endmodule

/* source/fetch_queue.sv */
`timescale 1ns/1ns
`include "frontend_params.svh"

module fetch_queue
  import frontend_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  input  logic         push_i,
  input  fetch_entry_t entry_i,
  input  logic         fetch_ready_i,
  output logic         room_o,
  output fetch_entry_t fetch_entry_o,
  output logic         fetch_valid_o
);

  localparam int unsigned DEPTH = `FE_QUEUE_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  fetch_entry_t mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             push;
  logic             pop;

  // pushes never meet a full queue thanks to room_o
  assign push = push_i & ~flush_i;
  assign pop  = fetch_valid_o & fetch_ready_i;

  // ------------------------------------------------------------
  // decode side
  // ------------------------------------------------------------
  assign fetch_valid_o = (count_q != '0);
  assign fetch_entry_o = mem_q[rd_ptr_q];

  // keep three slots for the words still in flight
  assign room_o = (count_q <= (PTR_W + 1)'(DEPTH - 3));

  // ------------------------------------------------------------
  // pointers and count
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // a pop in this cycle still completes on the port
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

endmodule

/* source/frontend.sv */
`timescale 1ns/1ns
`include "frontend_params.svh"

module frontend
  import frontend_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`FE_XLEN-1:0] boot_addr_i,
  output imem_req_t           imem_req_o,
  input  logic                imem_ready_i,
  input  imem_rsp_t           imem_rsp_i,
  input  resolve_t            resolve_i,
  input  logic                eret_i,
  input  logic [`FE_XLEN-1:0] epc_i,
  input  logic                ex_valid_i,
  input  logic [`FE_XLEN-1:0] trap_vector_i,
  output fetch_entry_t        fetch_entry_o,
  output logic                fetch_valid_o,
  input  logic                fetch_ready_i
);

  logic         flush;
  logic         drop;
  logic         room;
  logic         push;
  predict_t     predict;
  fetch_entry_t entry;

  // next pc and memory request
  pc_gen i_pc_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .boot_addr_i   (boot_addr_i),
    .ex_valid_i    (ex_valid_i),
    .trap_vector_i (trap_vector_i),
    .eret_i        (eret_i),
    .epc_i         (epc_i),
    .resolve_i     (resolve_i),
    .predict_i     (predict),
    .room_i        (room),
    .imem_ready_i  (imem_ready_i),
    .imem_req_o    (imem_req_o),
    .flush_o       (flush),
    .drop_o        (drop)
  );

  // response register, decode and static prediction
  scan_stage i_scan_stage (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .imem_rsp_i (imem_rsp_i),
    .req_addr_i (imem_req_o.addr),
    .drop_i     (drop),
    .flush_i    (flush),
    .predict_o  (predict),
    .push_o     (push),
    .entry_o    (entry)
  );

  // entries towards decode
  fetch_queue i_fetch_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush),
    .push_i        (push),
    .entry_i       (entry),
    .fetch_ready_i (fetch_ready_i),
    .room_o        (room),
    .fetch_entry_o (fetch_entry_o),
    .fetch_valid_o (fetch_valid_o)
  );

endmodule

/* testbench/tb_frontend.sv */
`timescale 1ns/1ns
`include "frontend_params.svh"

module tb_frontend
  import frontend_pkg::*;
();

  localparam int unsigned CLK_NS = 4;
  localparam logic [`FE_XLEN-1:0] BOOT_ADDR = 32'h0000_0180;
  // transfers to decode per test
  localparam int unsigned N_RESET  = 8;
  localparam int unsigned N_STREAM = 300;
  localparam int unsigned N_REDIR  = 300;
  localparam int unsigned N_BACKP  = 300;
  localparam int unsigned N_STALL  = 150;
  // generous bound, long memory stalls dominate
  localparam int unsigned CYC_PER_XFER = 60;
  localparam int unsigned TIMEOUT_NS = CLK_NS * (20 + CYC_PER_XFER *
      (N_RESET + N_STREAM + N_REDIR + N_BACKP + N_STALL));

  logic                clk_i;
  logic                rst_ni;
  logic [`FE_XLEN-1:0] boot_addr_i;
  imem_req_t           imem_req_o;
  logic                imem_ready_i;
  imem_rsp_t           imem_rsp_i;
  resolve_t            resolve_i;
  logic                eret_i;
  logic [`FE_XLEN-1:0] epc_i;
  logic                ex_valid_i;
  logic [`FE_XLEN-1:0] trap_vector_i;
  fetch_entry_t        fetch_entry_o;
  logic                fetch_valid_o;
  logic                fetch_ready_i;

  // program table, indexed by pc[7:2]
  logic [31:0]  prog [64];
  logic [31:0]  lfsr_q;
  // reference model state
  logic [31:0]  exp_pc;
  string        cur_test;
  int unsigned  errors;
  int unsigned  checks;
  int unsigned  xfers;
  int unsigned  total_xfers;
  int unsigned  err_base;
  int unsigned  tests_run;
  // stimulus modes of the running test
  int unsigned  mem_mode;
  int unsigned  dec_mode;
  logic         redir_en;
  int unsigned  stall_left;
  logic         stall_level;
  // what was seen in the previous cycle
  imem_req_t    prev_req;
  logic         prev_imem_ready;
  logic         prev_fvalid;
  logic         prev_fready;
  logic         prev_redirect;
  fetch_entry_t prev_entry;
  int unsigned  quiet;
  imem_rsp_t    rsp_next;

  frontend dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .boot_addr_i   (boot_addr_i),
    .imem_req_o    (imem_req_o),
    .imem_ready_i  (imem_ready_i),
    .imem_rsp_i    (imem_rsp_i),
    .resolve_i     (resolve_i),
    .eret_i        (eret_i),
    .epc_i         (epc_i),
    .ex_valid_i    (ex_valid_i),
    .trap_vector_i (trap_vector_i),
    .fetch_entry_o (fetch_entry_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // random source
  // ------------------------------------------------------------
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int unsigned n, output logic [31:0] v);
    int unsigned i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic fill_program();
    logic [31:0] kind;
    logic [31:0] w;
    int unsigned i;
    for (i = 0; i < 64; i++) begin
      rand_bits(3, kind);
      rand_bits(32, w);
      case (kind[2:0])
        3'd0, 3'd1: begin
          w[6:0] = `FE_OPC_BRANCH;
          // offset bit 1 cleared, targets stay word aligned
          w[8] = 1'b0;
        end
        3'd2: begin
          w[6:0] = `FE_OPC_JAL;
          w[21] = 1'b0;
        end
        3'd3:    w[6:0] = `FE_OPC_JALR;
        default: w[6:0] = 7'b0010011;
      endcase
      prog[i] = w;
    end
  endtask

  // ------------------------------------------------------------
  // reference model and checks
  // ------------------------------------------------------------
  // entry that decode should see for the word at pc
  function automatic fetch_entry_t expect_entry(input logic [31:0] pc);
    fetch_entry_t e;
    logic [31:0]  w;
    logic [31:0]  b_off;
    logic [31:0]  j_off;
    w = prog[pc[7:2]];
    b_off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    j_off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    e.pc = pc;
    e.instr = w;
    e.cf = CF_NONE;
    e.taken = 1'b0;
    case (w[6:0])
      `FE_OPC_BRANCH: begin
        e.cf = CF_BRANCH;
        // backward branch predicted taken
        e.taken = w[31];
      end
      `FE_OPC_JAL: begin
        e.cf = CF_JUMP;
        e.taken = 1'b1;
      end
      `FE_OPC_JALR: e.cf = CF_JUMPR;
      default:      e.cf = CF_NONE;
    endcase
    if (e.cf == CF_JUMP) begin
      e.target = pc + j_off;
    end else if (e.taken) begin
      e.target = pc + b_off;
    end else begin
      e.target = pc + 32'd4;
    end
    return e;
  endfunction

  task automatic compare(input string what, input logic [127:0] exp_v,
                         input logic [127:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      errors++;
      $display("CHECK FAILED %s: %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
    end
  endtask

  task automatic check_idle();
    compare("request valid low", 1'b0, imem_req_o.valid);
    compare("fetch valid low", 1'b0, fetch_valid_o);
  endtask

  // called at the rising edge, before any input moves
  task automatic sample_cycle();
    logic         redirect;
    logic         accepted;
    fetch_entry_t e;
    redirect = ex_valid_i | eret_i | resolve_i.valid;
    accepted = imem_req_o.valid & imem_ready_i;
    // stalled request holds once nothing behind it can redirect
    if (prev_req.valid && !prev_imem_ready && quiet >= 3) begin
      compare("request valid hold", 1'b1, imem_req_o.valid);
      compare("request address hold", prev_req.addr, imem_req_o.addr);
    end
    if (prev_fvalid && !prev_fready && !prev_redirect) begin
      compare("fetch valid hold", 1'b1, fetch_valid_o);
      compare("fetch entry hold", prev_entry, fetch_entry_o);
    end
    if (fetch_valid_o && fetch_ready_i) begin
      if (total_xfers == 0) begin
        compare("boot pc", BOOT_ADDR, fetch_entry_o.pc);
      end
      compare("pc", exp_pc, fetch_entry_o.pc);
      // expected fields of the word at the delivered pc
      e = expect_entry(fetch_entry_o.pc);
      compare("instr", e.instr, fetch_entry_o.instr);
      compare("cf", e.cf, fetch_entry_o.cf);
      compare("taken", e.taken, fetch_entry_o.taken);
      compare("target", e.target, fetch_entry_o.target);
      exp_pc = e.target;
      xfers++;
      total_xfers++;
    end
    // popped entry counts first, then the redirect restarts the walk
    if (ex_valid_i) begin
      exp_pc = trap_vector_i;
    end else if (eret_i) begin
      exp_pc = epc_i;
    end else if (resolve_i.valid) begin
      exp_pc = resolve_i.target;
    end
    // memory answers in the next cycle
    rsp_next.valid = accepted;
    rsp_next.data  = accepted ? prog[imem_req_o.addr[7:2]] : '0;
    prev_req        = imem_req_o;
    prev_imem_ready = imem_ready_i;
    prev_fvalid     = fetch_valid_o;
    prev_fready     = fetch_ready_i;
    prev_redirect   = redirect;
    prev_entry      = fetch_entry_o;
    quiet = (accepted || redirect) ? 0 : quiet + 1;
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] sel;
    imem_rsp_i = rsp_next;
    case (mem_mode)
      0: imem_ready_i = 1'b1;
      1: begin
        rand_bits(2, r);
        imem_ready_i = (r[1:0] != 2'b00);
      end
      default: begin
        if (stall_left == 0) begin
          rand_bits(1, r);
          stall_level = r[0];
          rand_bits(5, r);
          // short ready bursts between long stalls
          stall_left = stall_level ? 1 + r[2:0] : 4 + r[4:0];
        end
        imem_ready_i = stall_level;
        stall_left--;
      end
    endcase
    if (dec_mode == 0) begin
      fetch_ready_i = 1'b1;
    end else begin
      rand_bits(1, r);
      fetch_ready_i = r[0];
    end
    ex_valid_i = 1'b0;
    eret_i = 1'b0;
    resolve_i.valid = 1'b0;
    if (redir_en) begin
      rand_bits(4, r);
      if (r[3:0] == 4'd0) begin
        rand_bits(3, sel);
        // at least one source, sometimes several at once
        if (sel[2:0] == 3'd0) begin
          sel[2] = 1'b1;
        end
        rand_bits(30, r);
        trap_vector_i = {r[29:0], 2'b00};
        rand_bits(30, r);
        epc_i = {r[29:0], 2'b00};
        rand_bits(30, r);
        resolve_i.target = {r[29:0], 2'b00};
        ex_valid_i = sel[2];
        eret_i = sel[1];
        resolve_i.valid = sel[0];
      end
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_base = errors;
    xfers = 0;
  endtask

  task automatic run_cycles(input int unsigned n, input int unsigned mm,
                            input int unsigned dm, input logic re);
    mem_mode = mm;
    dec_mode = dm;
    redir_en = re;
    while (xfers < n) begin
      @(posedge clk_i);
      sample_cycle();
      #1;
      drive_inputs();
    end
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s: %0d transfers, %0d errors", cur_test, xfers, errors - err_base);
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    rst_ni = 1'b0;
    boot_addr_i = BOOT_ADDR;
    imem_ready_i = 1'b1;
    imem_rsp_i = '0;
    resolve_i = '0;
    eret_i = 1'b0;
    epc_i = '0;
    ex_valid_i = 1'b0;
    trap_vector_i = '0;
    fetch_ready_i = 1'b1;
    lfsr_q = 32'h4d96;
    exp_pc = BOOT_ADDR;
    errors = 0;
    checks = 0;
    total_xfers = 0;
    tests_run = 0;
    mem_mode = 0;
    dec_mode = 0;
    redir_en = 1'b0;
    stall_left = 0;
    stall_level = 1'b1;
    prev_req = '0;
    prev_imem_ready = 1'b1;
    prev_fvalid = 1'b0;
    prev_fready = 1'b1;
    prev_redirect = 1'b0;
    prev_entry = '0;
    quiet = 0;
    rsp_next = '0;
    fill_program();

    begin_test("reset");
    // flops take the reset value at each edge while reset is low
    repeat (5) begin
      @(posedge clk_i);
      #1;
      check_idle();
    end
    rst_ni = 1'b1;
    // boot address is loaded in this cycle
    @(posedge clk_i);
    check_idle();
    sample_cycle();
    #1;
    drive_inputs();
    run_cycles(N_RESET, 0, 0, 1'b0);
    end_test();

    begin_test("stream");
    run_cycles(N_STREAM, 0, 0, 1'b0);
    end_test();

    begin_test("redirect");
    run_cycles(N_REDIR, 1, 1, 1'b1);
    end_test();

    begin_test("backpressure");
    run_cycles(N_BACKP, 0, 1, 1'b0);
    end_test();

    begin_test("mem_stall");
    run_cycles(N_STALL, 2, 0, 1'b0);
    end_test();

    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired in test %s after %0d transfers", cur_test, xfers);
    $display("Test failures found");
    $finish;
  end

endmodule

/* files.f */
+incdir+source
source/frontend_pkg.sv
source/pc_gen.sv
source/scan_stage.sv
source/fetch_queue.sv
source/frontend.sv
testbench/tb_frontend.sv

/* Makefile */
FLIST := files.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f $(FLIST) --top-module frontend

sim:
	verilator --binary --timing -Wno-fatal -f $(FLIST) --top-module tb_frontend -Mdir obj_dir
	./obj_dir/Vtb_frontend | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
